/* hdl/coreDefs.sv */
////////////////////
// Shared encodings for the three-stage core slice
// Opcodes follow the MicroBlaze major-opcode numbering
// Opcode bit 3 set means the immediate form
// Branch flags live in the ra and rd fields of the branch word
// No loads, stores, shifts or multiplies are encoded
////////////////////

package coreDefs;

   // Register-register arithmetic and logic
   localparam logic [5:0] opcAdd   = 6'h00;
   localparam logic [5:0] opcRsub  = 6'h01;
   localparam logic [5:0] opcOr    = 6'h20;
   localparam logic [5:0] opcAnd   = 6'h21;
   localparam logic [5:0] opcXor   = 6'h22;

   // Immediate variants
   localparam logic [5:0] opcAddi  = 6'h08;
   localparam logic [5:0] opcRsubi = 6'h09;
   localparam logic [5:0] opcOri   = 6'h28;
   localparam logic [5:0] opcAndi  = 6'h29;
   localparam logic [5:0] opcXori  = 6'h2A;

   // Prefix and control flow
   localparam logic [5:0] opcImm   = 6'h2C;
   localparam logic [5:0] opcRtd   = 6'h2D;
   localparam logic [5:0] opcBru   = 6'h26;
   localparam logic [5:0] opcBcc   = 6'h27;
   localparam logic [5:0] opcBrui  = 6'h2E;
   localparam logic [5:0] opcBcci  = 6'h2F;

   // Field bit positions shared by decode, branch and the testbench
   localparam int immFormBit  = 3;
   localparam int bruDelayBit = 4;   // in ra
   localparam int bruAbsBit   = 3;   // in ra
   localparam int bccDelayBit = 4;   // in rd

   typedef struct packed {
      logic [5:0]  opc;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [10:0] func;
   } regFields;

   typedef struct packed {
      logic [5:0]  opc;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [15:0] imm;
   } immFields;

   // Same 32 bits, read either way
   typedef union packed {
      regFields regForm;
      immFields immForm;
   } instWord;

   // Condition held in rd[2:0] of a conditional branch
   typedef enum logic [2:0] {
      condEq = 3'd0,
      condNe = 3'd1,
      condLt = 3'd2,
      condLe = 3'd3,
      condGt = 3'd4,
      condGe = 3'd5
   } branchCond;

   // Operand source chosen in decode
   typedef enum logic {
      fwdReg = 1'b0,
      fwdExe = 1'b1
   } fwdSel;

endpackage

/* hdl/execBus.sv */
////////////////////
// One decoded instruction handed from decode to execute
// Operands are already forwarded when they arrive here
// valid low marks a bubble or an annulled slot
////////////////////

interface execBus #(
   parameter int addrWidth = 16
);

   logic                 valid;
   logic [5:0]           opc;
   logic [4:0]           rd;
   logic [4:0]           ra;
   // Forwarded register operands
   logic [31:0]          opA;
   logic [31:0]          opB;
   // Sign-extended or IMM-merged immediate
   logic [31:0]          imm32;
   // Address of this instruction
   logic [addrWidth-1:0] pc;
   logic                 isImmForm;

   // Decode side writes every field
   modport dec (output valid, opc, rd, ra, opA, opB, imm32, pc, isImmForm);

   // Execute side only reads
   modport exe (input valid, opc, rd, ra, opA, opB, imm32, pc, isImmForm);

endinterface

/* hdl/regFile.sv */
////////////////////
// 31 general registers, r0 is hardwired to zero
// Two combinational read ports, one write port
// Writes land at the clock edge and are blocked during reset
// Contents are not cleared by reset
////////////////////

module regFile (
   input  logic        gclk,
   input  logic        grst,
   input  logic        wrEn,
   input  logic [4:0]  wrAddr,
   input  logic [31:0] wrData,
   input  logic [4:0]  rdAddrA,
   input  logic [4:0]  rdAddrB,
   output logic [31:0] rdDataA,
   output logic [31:0] rdDataB
);

   // No storage behind address zero
   logic [31:0] regs [1:31];

   always_ff @(posedge gclk) begin
      if (!grst && wrEn && (wrAddr != 5'd0)) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Port A
   always_comb begin
      if (rdAddrA == 5'd0) begin
         rdDataA = '0;
      end else begin
         rdDataA = regs[rdAddrA];
      end
   end

   // Port B
   always_comb begin
      if (rdAddrB == 5'd0) begin
         rdDataB = '0;
      end else begin
         rdDataB = regs[rdAddrB];
      end
   end

endmodule

/* hdl/instDecoder.sv */
////////////////////
// Decode stage, one instruction per run cycle
// An IMM prefix covers only the next valid instruction
// Forwarding reaches back one instruction, older writes come from the register file
// A word only counts after one fetch has completed since reset
////////////////////

module instDecoder
   import coreDefs::*;
#(
   parameter int addrWidth = 16
) (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 run,
   input  logic [31:0]          iData,
   input  logic                 skip,
   input  logic [4:0]           exeRd,
   input  logic                 exeWr,
   input  logic [31:0]          exeResult,
   output logic [4:0]           rdAddrA,
   output logic [4:0]           rdAddrB,
   input  logic [31:0]          rdDataA,
   input  logic [31:0]          rdDataB,
   input  logic [addrWidth-1:0] pcIn,
   execBus.dec                  bus
);

   logic        fetchLive;
   logic        decValid;
   instWord     decWord;
   logic [5:0]  decOpc;
   logic        decImmForm;
   logic [15:0] imm16;
   logic [31:0] immFull;
   logic        immPend;
   logic [15:0] immHi;
   logic        passValid;
   fwdSel       selA;
   logic [31:0] opA;
   fwdSel       selB;
   logic [31:0] opB;

   // Field extraction from the word held in decode
   assign decOpc     = decWord.regForm.opc;
   assign decImmForm = decOpc[immFormBit];
   assign imm16      = decWord.immForm.imm;
   assign rdAddrA    = decWord.regForm.ra;
   assign rdAddrB    = decWord.regForm.rb;

   // Pending IMM supplies the upper half, otherwise sign extension
   assign immFull = immPend ? {immHi, imm16} : {{16{imm16[15]}}, imm16};

   // Take the execute result when it targets a source register
   assign selA = (exeWr && (exeRd == rdAddrA)) ? fwdExe : fwdReg;
   assign selB = (exeWr && (exeRd == rdAddrB)) ? fwdExe : fwdReg;
   assign opA  = (selA == fwdExe) ? exeResult : rdDataA;
   assign opB  = (selB == fwdExe) ? exeResult : rdDataB;

   // Annulled slots still move along, just without effect
   assign passValid = decValid & ~skip;

   always_ff @(posedge gclk) begin
      if (grst) begin
         fetchLive <= 1'b0;
         decValid  <= 1'b0;
         immPend   <= 1'b0;
         bus.valid <= 1'b0;
      end else if (run) begin
         fetchLive <= 1'b1;
         decValid  <= fetchLive;
         bus.valid <= passValid;
         // Prefix state changes only on instructions that really issue
         if (passValid) begin
            immPend <= (decOpc == opcImm);
         end
      end
   end

   // Payload registers, no reset
   always_ff @(posedge gclk) begin
      if (run) begin
         decWord       <= iData;
         bus.opc       <= decOpc;
         bus.rd        <= decWord.regForm.rd;
         bus.ra        <= rdAddrA;
         bus.opA       <= opA;
         bus.opB       <= opB;
         bus.imm32     <= immFull;
         bus.pc        <= pcIn;
         bus.isImmForm <= decImmForm;
         if (passValid && (decOpc == opcImm)) begin
            immHi <= imm16;
         end
      end
   end

endmodule

/* hdl/aluUnit.sv */
////////////////////
// Execute stage arithmetic, logic and branch targets
// result is the ALU value, or the target on a branch
// wrData differs only for a linking branch, which writes its own PC
// wbEn pulses once per run edge that retires a write
////////////////////

module aluUnit
   import coreDefs::*;
#(
   parameter int addrWidth = 16
) (
   input  logic        gclk,
   input  logic        grst,
   input  logic        run,
   execBus.exe         bus,
   output logic [31:0] result,
   output logic [31:0] wrData,
   output logic        wrEn,
   output logic        wbEn,
   output logic [4:0]  wbAddr,
   output logic [31:0] wbData
);

   logic [31:0] operand;
   logic [31:0] pcExt;
   logic        writes;
   logic        isBru;

   // Second operand by form
   assign operand = bus.isImmForm ? bus.imm32 : bus.opB;
   assign pcExt   = {{(32 - addrWidth){1'b0}}, bus.pc};
   assign isBru   = (bus.opc == opcBru) || (bus.opc == opcBrui);

   always_comb begin
      result = '0;
      writes = 1'b0;
      case (bus.opc)
         opcAdd, opcAddi: begin
            result = bus.opA + operand;
            writes = 1'b1;
         end
         // Reverse subtract, b minus a
         opcRsub, opcRsubi: begin
            result = operand - bus.opA;
            writes = 1'b1;
         end
         opcAnd, opcAndi: begin
            result = bus.opA & operand;
            writes = 1'b1;
         end
         opcOr, opcOri: begin
            result = bus.opA | operand;
            writes = 1'b1;
         end
         opcXor, opcXori: begin
            result = bus.opA ^ operand;
            writes = 1'b1;
         end
         // Absolute or PC-relative, rd gets the link
         opcBru, opcBrui: begin
            result = bus.ra[bruAbsBit] ? operand : pcExt + operand;
            writes = 1'b1;
         end
         opcBcc, opcBcci: result = pcExt + operand;
         opcRtd:          result = bus.opA + bus.imm32;
         default:         result = '0;
      endcase
   end

   assign wrData = isBru ? pcExt : result;
   assign wrEn   = bus.valid & writes & (bus.rd != 5'd0);

   // Retire the write to the outside
   always_ff @(posedge gclk) begin
      if (grst) begin
         wbEn <= 1'b0;
      end else begin
         wbEn <= run & wrEn;
      end
   end

   always_ff @(posedge gclk) begin
      if (run && wrEn) begin
         wbAddr <= bus.rd;
         wbData <= wrData;
      end
   end

endmodule

/* hdl/branchUnit.sv */
////////////////////
// Branch decision and PC pipeline
// Branches resolve in execute and redirect the fetch address at once
// A taken branch always drops the wrong-path word behind its follower
// Without the delay flag the follower itself is dropped as well
// Addresses count instruction words
////////////////////

module branchUnit
   import coreDefs::*;
#(
   parameter int addrWidth = 16
) (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 run,
   execBus.exe                  bus,
   input  logic [31:0]          result,
   output logic [addrWidth-1:0] iAddr,
   output logic [addrWidth-1:0] pcDec,
   output logic                 skip
);

   logic                 isBru;
   logic                 isBcc;
   logic                 isRtd;
   logic                 opZero;
   logic                 opNeg;
   branchCond            cond;
   logic                 condMet;
   logic                 taken;
   logic                 delay;
   logic                 takenQ;
   logic [addrWidth-1:0] seqAddr;
   logic [addrWidth-1:0] fetchPc;

   // Opcode classes, both forms
   assign isBru = (bus.opc == opcBru) || (bus.opc == opcBrui);
   assign isBcc = (bus.opc == opcBcc) || (bus.opc == opcBcci);
   assign isRtd = (bus.opc == opcRtd);

   // Conditions look only at the forwarded ra value
   assign opZero = (bus.opA == 32'd0);
   assign opNeg  = bus.opA[31];
   assign cond   = branchCond'(bus.rd[2:0]);

   always_comb begin
      case (cond)
         condEq:  condMet = opZero;
         condNe:  condMet = ~opZero;
         condLt:  condMet = opNeg;
         condLe:  condMet = opNeg | opZero;
         condGt:  condMet = ~(opNeg | opZero);
         condGe:  condMet = ~opNeg;
         default: condMet = 1'b0;
      endcase
   end

   // Unconditional and return always go, conditional on the test
   assign taken = bus.valid & (isBru | isRtd | (isBcc & condMet));

   // RTD always has a delay slot
   assign delay = (isBru & bus.ra[bruDelayBit])
                | (isBcc & bus.rd[bccDelayBit])
                | isRtd;

   // Now: drop the follower if undelayed
   // One cycle on: drop the word fetched before the redirect
   assign skip = (taken & ~delay) | takenQ;

   // Redirect in the cycle the branch executes
   assign iAddr = taken ? result[addrWidth-1:0] : seqAddr;

   always_ff @(posedge gclk) begin
      if (grst) begin
         seqAddr <= '0;
         fetchPc <= '0;
         pcDec   <= '0;
         takenQ  <= 1'b0;
      end else if (run) begin
         // Address after the one the memory samples now
         seqAddr <= iAddr + 1'b1;
         // Word now fetching, then word entering decode
         fetchPc <= iAddr;
         pcDec   <= fetchPc;
         takenQ  <= taken;
      end
   end

endmodule

/* hdl/coreTop.sv */
////////////////////
// Three-stage core slice top level
// Instruction memory is external and answers iAddr one run cycle later
// run low freezes the whole pipeline
// wbEn/wbAddr/wbData mirror each register write as it retires
////////////////////

module coreTop #(
   parameter int addrWidth = 16
) (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 run,
   output logic [addrWidth-1:0] iAddr,
   input  logic [31:0]          iData,
   output logic                 wbEn,
   output logic [4:0]           wbAddr,
   output logic [31:0]          wbData
);

   logic                 skip;
   logic [4:0]           rdAddrA;
   logic [4:0]           rdAddrB;
   logic [31:0]          rdDataA;
   logic [31:0]          rdDataB;
   logic [31:0]          result;
   logic [31:0]          wrData;
   logic                 wrEn;
   logic [addrWidth-1:0] pcDec;

   // Decode to execute
   execBus #(.addrWidth(addrWidth)) exeBus ();

   instDecoder #(.addrWidth(addrWidth)) u_instDecoder (
      .gclk      (gclk),
      .grst      (grst),
      .run       (run),
      .iData     (iData),
      .skip      (skip),
      .exeRd     (exeBus.rd),
      .exeWr     (wrEn),
      .exeResult (wrData),
      .rdAddrA   (rdAddrA),
      .rdAddrB   (rdAddrB),
      .rdDataA   (rdDataA),
      .rdDataB   (rdDataB),
      .pcIn      (pcDec),
      .bus       (exeBus.dec)
   );

   // Write address comes straight from the execute slot
   regFile u_regFile (
      .gclk    (gclk),
      .grst    (grst),
      .wrEn    (wrEn),
      .wrAddr  (exeBus.rd),
      .wrData  (wrData),
      .rdAddrA (rdAddrA),
      .rdAddrB (rdAddrB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB)
   );

   aluUnit #(.addrWidth(addrWidth)) u_aluUnit (
      .gclk   (gclk),
      .grst   (grst),
      .run    (run),
      .bus    (exeBus.exe),
      .result (result),
      .wrData (wrData),
      .wrEn   (wrEn),
      .wbEn   (wbEn),
      .wbAddr (wbAddr),
      .wbData (wbData)
   );

   branchUnit #(.addrWidth(addrWidth)) u_branchUnit (
      .gclk   (gclk),
      .grst   (grst),
      .run    (run),
      .bus    (exeBus.exe),
      .result (result),
      .iAddr  (iAddr),
      .pcDec  (pcDec),
      .skip   (skip)
   );

endmodule

/* dv/coreTop_props.sv */
////////////////////
// Bound checks on the core top level
// Sampled on the rising clock, run is taken as the level at that edge
// Only reset, stall and writeback port rules are covered
////////////////////

module coreTop_props #(
   parameter int addrWidth = 16
) (
   input logic                 gclk,
   input logic                 grst,
   input logic                 run,
   input logic [addrWidth-1:0] iAddr,
   input logic                 wbEn,
   input logic [4:0]           wbAddr
);

   // Reset kills any pending writeback pulse
   resetClearsWb: assert property (@(posedge gclk) grst |=> !wbEn)
      else $error("wbEn high in the cycle after reset");

   // A run-low edge freezes the fetch address
   stallHoldsAddr: assert property (@(posedge gclk) disable iff (grst) !run |=> $stable(iAddr))
      else $error("iAddr moved across a stalled edge");

   // Nothing retires on a stalled edge
   stallNoWb: assert property (@(posedge gclk) disable iff (grst) !run |=> !wbEn)
      else $error("wbEn pulsed after a stalled edge");

   // r0 writes never leave the core
   noZeroWrite: assert property (@(posedge gclk) disable iff (grst) wbEn |-> wbAddr != 5'd0)
      else $error("wbEn reported a write to r0");

endmodule

bind coreTop coreTop_props #(.addrWidth(addrWidth)) u_coreTopProps (
   .gclk   (gclk),
   .grst   (grst),
   .run    (run),
   .iAddr  (iAddr),
   .wbEn   (wbEn),
   .wbAddr (wbAddr)
);

/* dv/coreTb.sv */
////////////////////
// Testbench for the core slice, memory model covers 256 words
// Expected writes come from an ISA-level model of the program
// Programs must write every register before reading it
// Each program ends in a non-delayed branch to itself
////////////////////

module coreTb
   import coreDefs::*;
();

   localparam logic [4:0] raDelay = 5'b1 << bruDelayBit;
   localparam logic [4:0] raAbs   = 5'b1 << bruAbsBit;
   localparam logic [4:0] rdDelay = 5'b1 << bccDelayBit;

   logic        gclk;
   logic        grst;
   logic        run;
   logic [15:0] iAddr;
   logic [31:0] iData;
   logic        wbEn;
   logic [4:0]  wbAddr;
   logic [31:0] wbData;

   logic [31:0] mem [0:255];
   logic [7:0]  progLen;
   logic [7:0]  sampAddr;
   logic        sampRun;
   logic [31:0] rngState;
   logic [4:0]  expAddr [$];
   logic [31:0] expData [$];
   int          expIdx;
   int          cycleCount;
   int          cycleLimit;
   int          errorCount;
   int          checkCount;
   int          testsPassed;
   int          testsFailed;

   coreTop #(.addrWidth(16)) u_coreTop (
      .gclk   (gclk),
      .grst   (grst),
      .run    (run),
      .iAddr  (iAddr),
      .iData  (iData),
      .wbEn   (wbEn),
      .wbAddr (wbAddr),
      .wbData (wbData)
   );

   initial begin
      gclk = 1'b0;
      forever #4 gclk = ~gclk;
   end

   // Memory sees the address mid-cycle, run already holds the next edge's level
   always @(negedge gclk) begin
      sampAddr = iAddr[7:0];
      sampRun  = run;
   end

   // Word answered one cycle after the sampling edge
   always @(posedge gclk) begin
      #1;
      if (sampRun) begin
         iData = mem[sampAddr];
      end
   end

   always @(posedge gclk) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
         $display("Timeout after %0d cycles, the write stream never completed", cycleCount);
         $display("test failed");
         $finish;
      end
   end

   task automatic compareValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      end
   endtask

   // Each writeback pulse is one cycle wide, so one negedge sees it once
   always @(negedge gclk) begin
      if (!grst && wbEn) begin
         if (expIdx < expAddr.size()) begin
            compareValue("wbAddr", 32'(wbAddr), 32'(expAddr[expIdx]));
            compareValue("wbData", wbData, expData[expIdx]);
            expIdx++;
         end else begin
            errorCount++;
            $display("Unexpected write to r%0d at %0t after the program finished", wbAddr, $time);
         end
      end
   end

   function automatic logic [15:0] rand16();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState[15:0];
   endfunction

   function automatic logic [31:0] regInst(input logic [5:0] opc, input logic [4:0] rd,
                                           input logic [4:0] ra, input logic [4:0] rb);
      return {opc, rd, ra, rb, 11'd0};
   endfunction

   function automatic logic [31:0] immInst(input logic [5:0] opc, input logic [4:0] rd,
                                           input logic [4:0] ra, input logic [15:0] imm);
      return {opc, rd, ra, imm};
   endfunction

   // ISA model, walks the program and lists the register writes in order
   function automatic int modelProgram();
      logic [31:0] regs [0:31];
      logic [31:0] w;
      logic [31:0] imm32;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] val;
      logic [15:0] pc;
      logic [15:0] target;
      logic [15:0] slotTarget;
      logic [15:0] immHi;
      logic [5:0]  opc;
      logic [4:0]  rd;
      logic        immPend;
      logic        inSlot;
      logic        taken;
      logic        delay;
      logic        cond;
      logic        writes;
      int          steps;
      expAddr.delete();
      expData.delete();
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
      pc      = '0;
      immHi   = '0;
      immPend = 1'b0;
      inSlot  = 1'b0;
      slotTarget = '0;
      steps   = 0;
      while (steps < 1000) begin
         w   = mem[pc[7:0]];
         opc = w[31:26];
         rd  = w[25:21];
         steps++;
         // A prefix covers exactly this instruction
         imm32   = immPend ? {immHi, w[15:0]} : {{16{w[15]}}, w[15:0]};
         immPend = 1'b0;
         a       = regs[w[20:16]];
         b       = opc[immFormBit] ? imm32 : regs[w[15:11]];
         val     = '0;
         writes  = 1'b0;
         taken   = 1'b0;
         delay   = 1'b0;
         target  = '0;
         case (opc)
            opcAdd, opcAddi: begin
               val    = a + b;
               writes = 1'b1;
            end
            opcRsub, opcRsubi: begin
               val    = b - a;
               writes = 1'b1;
            end
            opcAnd, opcAndi: begin
               val    = a & b;
               writes = 1'b1;
            end
            opcOr, opcOri: begin
               val    = a | b;
               writes = 1'b1;
            end
            opcXor, opcXori: begin
               val    = a ^ b;
               writes = 1'b1;
            end
            opcImm: begin
               immPend = 1'b1;
               immHi   = w[15:0];
            end
            // Link is the branch's own address
            opcBru, opcBrui: begin
               val    = {16'd0, pc};
               writes = 1'b1;
               taken  = 1'b1;
               delay  = w[16 + bruDelayBit];
               target = w[16 + bruAbsBit] ? b[15:0] : pc + b[15:0];
            end
            opcBcc, opcBcci: begin
               case (rd[2:0])
                  condEq:  cond = (a == 32'd0);
                  condNe:  cond = (a != 32'd0);
                  condLt:  cond = a[31];
                  condLe:  cond = a[31] || (a == 32'd0);
                  condGt:  cond = !a[31] && (a != 32'd0);
                  condGe:  cond = !a[31];
                  default: cond = 1'b0;
               endcase
               taken  = cond;
               delay  = rd[bccDelayBit];
               target = pc + b[15:0];
            end
            opcRtd: begin
               taken  = 1'b1;
               delay  = 1'b1;
               target = a[15:0] + imm32[15:0];
            end
            default: begin
               writes = 1'b0;
            end
         endcase
         if (writes && (rd != 5'd0)) begin
            regs[rd] = val;
            expAddr.push_back(rd);
            expData.push_back(val);
         end
         if (inSlot) begin
            pc     = slotTarget;
            inSlot = 1'b0;
         end else if (taken && delay) begin
            inSlot     = 1'b1;
            slotTarget = target;
            pc         = pc + 16'd1;
         end else if (taken) begin
            // Self loop marks the end
            if (target == pc) begin
               return steps;
            end
            pc = target;
         end else begin
            pc = pc + 16'd1;
         end
      end
      return steps;
   endfunction

   task automatic waitDrive();
      @(posedge gclk);
      #1;
   endtask

   task automatic emit(input logic [31:0] w);
      mem[progLen] = w;
      progLen = progLen + 8'd1;
   endtask

   task automatic endProgram();
      emit(immInst(opcBrui, 5'd0, 5'd0, 16'd0));
   endtask

   // Unused words are ORs into r0, tagged with their own address
   task automatic holdReset();
      waitDrive();
      grst = 1'b1;
      waitDrive();
      waitDrive();
      for (int i = 0; i < 256; i++) begin
         mem[i] = {opcOr, 5'd0, 5'd0, 5'd0, 3'd0, 8'(i)};
      end
      progLen = '0;
   endtask

   // Every step leans on the one just before it
   task automatic buildArith();
      emit(immInst(opcAddi, 5'd1, 5'd0, rand16()));
      emit(immInst(opcAddi, 5'd2, 5'd0, rand16()));
      emit(regInst(opcAdd, 5'd3, 5'd1, 5'd2));
      emit(regInst(opcRsub, 5'd4, 5'd3, 5'd1));
      emit(regInst(opcAnd, 5'd5, 5'd4, 5'd3));
      emit(regInst(opcOr, 5'd6, 5'd5, 5'd2));
      emit(regInst(opcXor, 5'd7, 5'd6, 5'd5));
      emit(immInst(opcRsubi, 5'd8, 5'd7, rand16()));
      emit(immInst(opcAndi, 5'd9, 5'd8, rand16()));
      emit(immInst(opcOri, 5'd10, 5'd9, rand16()));
      emit(immInst(opcXori, 5'd11, 5'd10, rand16()));
      emit(regInst(opcAdd, 5'd12, 5'd11, 5'd11));
      endProgram();
   endtask

   task automatic buildImm();
      emit(immInst(opcImm, 5'd0, 5'd0, rand16()));
      emit(immInst(opcAddi, 5'd1, 5'd0, rand16()));
      emit(immInst(opcImm, 5'd0, 5'd0, rand16()));
      emit(immInst(opcOri, 5'd2, 5'd0, rand16()));
      // Negative low half shows sign extension is back
      emit(immInst(opcAddi, 5'd3, 5'd0, rand16() | 16'h8000));
      emit(immInst(opcImm, 5'd0, 5'd0, rand16()));
      emit(regInst(opcAdd, 5'd4, 5'd1, 5'd2));
      emit(immInst(opcAddi, 5'd5, 5'd0, rand16() | 16'h8000));
      emit(immInst(opcImm, 5'd0, 5'd0, rand16()));
      emit(immInst(opcXori, 5'd6, 5'd1, rand16()));
      emit(regInst(opcAdd, 5'd7, 5'd6, 5'd3));
      endProgram();
   endtask

   // r2 and r7 are only written on annulled or skipped paths
   task automatic buildJumps();
      emit(immInst(opcAddi, 5'd1, 5'd0, 16'd5));
      emit(immInst(opcBrui, 5'd10, 5'd0, 16'd3));
      emit(immInst(opcAddi, 5'd2, 5'd0, 16'h77));
      emit(immInst(opcAddi, 5'd2, 5'd0, 16'h78));
      emit(immInst(opcBrui, 5'd11, raDelay, 16'd3));
      emit(immInst(opcAddi, 5'd3, 5'd0, 16'h33));
      emit(immInst(opcAddi, 5'd2, 5'd0, 16'h99));
      emit(immInst(opcAddi, 5'd4, 5'd0, 16'd10));
      emit(regInst(opcBru, 5'd12, raDelay | raAbs, 5'd4));
      emit(immInst(opcAddi, 5'd5, 5'd1, 16'd1));
      emit(immInst(opcAddi, 5'd6, 5'd0, 16'd4));
      emit(regInst(opcBru, 5'd13, 5'd0, 5'd6));
      emit(immInst(opcAddi, 5'd2, 5'd0, 16'h55));
      emit(immInst(opcAddi, 5'd2, 5'd0, 16'h56));
      emit(immInst(opcAddi, 5'd2, 5'd0, 16'h57));
      emit(immInst(opcBrui, 5'd0, raAbs, 16'd18));
      emit(immInst(opcAddi, 5'd7, 5'd0, 16'd1));
      emit(immInst(opcAddi, 5'd7, 5'd0, 16'd2));
      emit(regInst(opcAdd, 5'd8, 5'd10, 5'd13));
      endProgram();
   endtask

   // Follower marks not-taken or delayed, the next word always runs
   task automatic buildCond();
      logic [15:0] base;
      emit(immInst(opcAddi, 5'd1, 5'd0, 16'd0));
      emit(immInst(opcAddi, 5'd2, 5'd0, 16'd5));
      emit(immInst(opcAddi, 5'd3, 5'd0, 16'hFFFD));
      for (int c = 0; c < 6; c++) begin
         for (int r = 1; r < 4; r++) begin
            emit(immInst(opcBcci, 5'(c) | ((((c + r) % 2) == 1) ? rdDelay : 5'd0),
                         5'(r), 16'd2));
            emit(immInst(opcAddi, 5'd20, 5'd0, 16'(c * 8 + r)));
            emit(immInst(opcAddi, 5'd21, 5'd0, 16'(c * 8 + r + 64)));
         end
      end
      // Call with link into r15, return with RTD two words past the call
      base = {8'd0, progLen};
      emit(immInst(opcBrui, 5'd15, raDelay, 16'd4));
      emit(immInst(opcAddi, 5'd22, 5'd0, 16'd1));
      emit(immInst(opcAddi, 5'd23, 5'd15, 16'd2));
      endProgram();
      emit(immInst(opcAddi, 5'd24, 5'd0, base));
      emit(immInst(opcRtd, 5'd0, 5'd15, 16'd2));
      emit(immInst(opcAddi, 5'd25, 5'd0, 16'd4));
   endtask

   task automatic runProgram(input string name, input bit withStalls, input bit withReset);
      int steps;
      int errsBefore;
      int restartAt;
      steps = modelProgram();
      cycleLimit = cycleLimit + 5 * steps + 30;
      if (withReset) begin
         cycleLimit = cycleLimit + 5 * steps + 30;
      end
      errsBefore = errorCount;
      expIdx     = 0;
      restartAt  = withReset ? 3 : -1;
      waitDrive();
      grst = 1'b0;
      while (expIdx < expAddr.size()) begin
         waitDrive();
         if (withStalls) begin
            run = (rand16() % 16'd4) != 16'd0;
            if (!run) begin
               cycleLimit++;
            end
         end
         if ((restartAt >= 0) && (expIdx >= restartAt)) begin
            grst = 1'b1;
            waitDrive();
            waitDrive();
            // Fetch is back at the reset vector before release
            compareValue("iAddr", 32'(iAddr), 32'd0);
            expIdx    = 0;
            restartAt = -1;
            grst      = 1'b0;
         end
      end
      run = 1'b1;
      // Trailing window catches writes past the end
      repeat (12) waitDrive();
      if (errorCount == errsBefore) begin
         testsPassed++;
         $display("%s: %0d writes, %0d instructions, ok", name, expAddr.size(), steps);
      end else begin
         testsFailed++;
         $display("%s: %0d errors", name, errorCount - errsBefore);
      end
   endtask

   initial begin
      grst        = 1'b1;
      run         = 1'b1;
      iData       = '0;
      progLen     = '0;
      rngState    = 32'd43291;
      expIdx      = 0;
      cycleCount  = 0;
      cycleLimit  = 40;
      errorCount  = 0;
      checkCount  = 0;
      testsPassed = 0;
      testsFailed = 0;
      repeat (16) @(posedge gclk);
      holdReset();
      buildArith();
      runProgram("arith forwarding", 1'b0, 1'b0);
      holdReset();
      buildImm();
      runProgram("imm prefix", 1'b0, 1'b0);
      holdReset();
      buildJumps();
      runProgram("unconditional branches", 1'b0, 1'b0);
      holdReset();
      buildCond();
      runProgram("conditional branches and rtd", 1'b0, 1'b0);
      holdReset();
      buildCond();
      runProgram("random stalls", 1'b1, 1'b0);
      holdReset();
      buildArith();
      runProgram("reset mid-program", 1'b0, 1'b1);
      $display("tests %0d, ok %0d, bad %0d, checks %0d, errors %0d",
               testsPassed + testsFailed, testsPassed, testsFailed, checkCount, errorCount);
      if ((errorCount == 0) && (testsFailed == 0)) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* project.f */
hdl/coreDefs.sv
hdl/execBus.sv
hdl/regFile.sv
hdl/instDecoder.sv
hdl/aluUnit.sv
hdl/branchUnit.sv
hdl/coreTop.sv
dv/coreTop_props.sv
dv/coreTb.sv

/* run.sh */
#!/bin/sh
# Build the core testbench with Verilator, run it, and look for the pass line
verilator --binary --timing --assert -f project.f --top-module coreTb -o coreSim \
   && ./obj_dir/coreSim | tee /dev/stderr | grep -q "^test passed$" \
   && echo "simulation ok" \
   || { echo "simulation not ok"; exit 1; }
